/* design/keccak_pkg.sv */
`default_nettype none

package keccak_pkg;

  localparam int LANE_W   = 64;
  localparam int STATE_W  = 1600;
  localparam int RATE_W   = 1088;
  localparam int CAP_W    = 512;
  localparam int HEADER_W = 608;
  localparam int NONCE_W  = 32;
  localparam int TARGET_W = 32;

  // lanes per row and rows per state
  localparam int GRID = 5;

  localparam int NUM_ROUNDS = 24;

  // lane whose value is the share hash
  localparam int HASH_LANE_X = 3;
  localparam int HASH_LANE_Y = 0;

  typedef logic [LANE_W-1:0] lane_t;

  // indexed [y][x], lane (0,0) sits in the top 64 bits
  typedef lane_t [0:GRID-1][0:GRID-1] state_t;

  typedef struct packed {
    logic [HEADER_W-1:0] header;
    logic [NONCE_W-1:0]  nonce;
  } job_t;

  // rho rotation amounts, left rotate, indexed [y][x]
  localparam int unsigned ROT_OFFSETS [GRID][GRID] = '{
    '{ 0,  1, 62, 28, 27},
    '{36, 44,  6, 55, 20},
    '{ 3, 10, 43, 25, 39},
    '{41, 45, 15, 21,  8},
    '{18,  2, 61, 56, 14}
  };

  // compressed iota constants, bit j lands on lane bit 2**j - 1
  localparam logic [6:0] RC_BITS [NUM_ROUNDS] = '{
    7'h01, 7'h1a, 7'h5e, 7'h70,
    7'h1f, 7'h21, 7'h79, 7'h55,
    7'h0e, 7'h0c, 7'h35, 7'h26,
    7'h3f, 7'h4f, 7'h5d, 7'h53,
    7'h52, 7'h48, 7'h16, 7'h66,
    7'h79, 7'h58, 7'h21, 7'h74
  };

  // full 64-bit round constant for round idx
  function automatic lane_t round_constant(input int unsigned idx);
    logic [6:0] bits;
    lane_t      rc;
    if (idx < NUM_ROUNDS)
    begin
      bits = RC_BITS[idx];
    end
    else
    begin
      bits = '0; // out of range rounds add nothing
    end
    rc = '0;
    for (int j = 0; j < 7; j++)
    begin
      rc[(1 << j) - 1] = bits[j];
    end
    return rc;
  endfunction

endpackage

`default_nettype wire

/* design/keccak_absorb.sv */
`timescale 1ns/1ps
`default_nettype none

module keccak_absorb
  import keccak_pkg::*;
(
  input  job_t   job,
  output state_t state
);

  localparam int PAD_W      = RATE_W - HEADER_W - NONCE_W;
  localparam int RATE_LANES = RATE_W / LANE_W;
  localparam int LANE_BYTES = LANE_W / 8;

  // keccak pad10*1 style tail, 01 first and 80 last
  localparam logic [PAD_W-1:0] PAD_TAIL = {8'h01, {(PAD_W - 16){1'b0}}, 8'h80};

  logic [RATE_W-1:0] block;
  logic [RATE_W-1:0] block_le;

  if (RATE_W + CAP_W != STATE_W)
  begin : g_size_check
    $error("rate plus capacity does not fill the state");
  end

  assign block = {job.header, job.nonce, PAD_TAIL};

  // header words arrive big endian, lanes are little endian
  always_comb
  begin
    for (int w = 0; w < RATE_LANES; w++)
    begin
      for (int b = 0; b < LANE_BYTES; b++)
      begin
        block_le[w*LANE_W + b*8 +: 8] = block[w*LANE_W + (LANE_BYTES-1-b)*8 +: 8];
      end
    end
  end

  assign state = {block_le, {CAP_W{1'b0}}}; // capacity starts at zero

endmodule

`default_nettype wire

/* design/keccak_round.sv */
`timescale 1ns/1ps
`default_nettype none

module keccak_round
  import keccak_pkg::*;
#(
  parameter int ROUND_IDX = 0
) (
  input  logic   clk,
  input  state_t state_in,
  output state_t state_out
);

  localparam lane_t RC = round_constant(ROUND_IDX);

  lane_t  col_par [GRID];
  lane_t  theta_d [GRID];
  state_t rho_d;
  state_t rho_q;
  state_t pi_st;
  state_t chi_st;

  function automatic lane_t rotl(input lane_t a, input int unsigned n);
    return (a << n) | (a >> (LANE_W - n));
  endfunction

  // column parities
  always_comb
  begin
    for (int x = 0; x < GRID; x++)
    begin
      col_par[x] = '0;
      for (int y = 0; y < GRID; y++)
      begin
        col_par[x] = col_par[x] ^ state_in[y][x];
      end
    end
  end

  // theta column effect
  always_comb
  begin
    for (int x = 0; x < GRID; x++)
    begin
      theta_d[x] = col_par[(x + GRID - 1) % GRID] ^ rotl(col_par[(x + 1) % GRID], 1);
    end
  end

  // theta applied then rho
  always_comb
  begin
    for (int y = 0; y < GRID; y++)
    begin
      for (int x = 0; x < GRID; x++)
      begin
        rho_d[y][x] = rotl(state_in[y][x] ^ theta_d[x], ROT_OFFSETS[y][x]);
      end
    end
  end

  // mid-round register
  always_ff @(posedge clk)
  begin
    rho_q <= rho_d;
  end

  // pi: lane (x,y) takes old lane (x+3y, x)
  always_comb
  begin
    for (int y = 0; y < GRID; y++)
    begin
      for (int x = 0; x < GRID; x++)
      begin
        pi_st[y][x] = rho_q[x][(x + 3*y) % GRID];
      end
    end
  end

  // chi along each row
  always_comb
  begin
    for (int y = 0; y < GRID; y++)
    begin
      for (int x = 0; x < GRID; x++)
      begin
        chi_st[y][x] = pi_st[y][x] ^ (~pi_st[y][(x + 1) % GRID] & pi_st[y][(x + 2) % GRID]);
      end
    end
  end

  always_comb
  begin
    state_out       = chi_st;
    state_out[0][0] = chi_st[0][0] ^ RC; // iota
  end

  // a clean register must never yield x after the second half
  a_known_out : assert property (
    @(posedge clk) !$isunknown(rho_q) |-> !$isunknown(state_out)
  ) else $error("round %0d output has unknown bits", ROUND_IDX);

endmodule

`default_nettype wire

/* design/keccak_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module keccak_pipeline
  import keccak_pkg::*;
#(
  parameter int NUM_ROUNDS = keccak_pkg::NUM_ROUNDS
) (
  input  logic   clk,
  input  state_t state_in,
  output state_t state_out
);

  if (NUM_ROUNDS < 1)
  begin : g_param_check
    $error("pipeline needs at least one round");
  end

  genvar r;

  for (r = 0; r < NUM_ROUNDS; r++)
  begin : g_round
    state_t round_in;
    state_t round_out;

    if (r == 0)
    begin : g_first
      assign round_in = state_in; // absorb output feeds round 0 directly
    end
    else
    begin : g_next
      // inter-round register
      always_ff @(posedge clk)
      begin
        round_in <= g_round[r-1].round_out;
      end
    end

    keccak_round #(
      .ROUND_IDX (r)
    ) keccak_round_i (
      .clk       (clk),
      .state_in  (round_in),
      .state_out (round_out)
    );
  end

  // no register after the last round, share_check takes it
  assign state_out = g_round[NUM_ROUNDS-1].round_out;

endmodule

`default_nettype wire

/* design/share_check.sv */
`timescale 1ns/1ps
`default_nettype none

module share_check
  import keccak_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  state_t              state_in,
  input  logic [TARGET_W-1:0] target,
  output lane_t               hash,
  output logic                gn_match
);

  logic [TARGET_W-1:0] hash_hi;

  always_ff @(posedge clk)
  begin
    hash <= state_in[HASH_LANE_Y][HASH_LANE_X];
  end

  assign hash_hi = hash[LANE_W-1 -: TARGET_W];

  // share when upper half does not exceed target
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      gn_match <= 1'b0;
    end
    else
    begin
      gn_match <= (hash_hi <= target);
    end
  end

  a_match_reset : assert property (
    @(posedge clk) !rst_n |=> !gn_match
  ) else $error("gn_match high right after reset");

endmodule

`default_nettype wire

/* design/keccak_miner_top.sv */
`timescale 1ns/1ps
`default_nettype none

module keccak_miner_top
  import keccak_pkg::*;
#(
  parameter int NUM_ROUNDS = keccak_pkg::NUM_ROUNDS
) (
  input  logic                clk,
  input  logic                rst_n,
  input  job_t                job,
  input  logic [TARGET_W-1:0] target,
  output lane_t               hash,
  output logic                gn_match
);

  state_t init_state;
  state_t final_state;

  keccak_absorb keccak_absorb_i (
    .job   (job),
    .state (init_state)
  );

  // 2*NUM_ROUNDS-1 cycles deep
  keccak_pipeline #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) keccak_pipeline_i (
    .clk       (clk),
    .state_in  (init_state),
    .state_out (final_state)
  );

  share_check share_check_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .state_in (final_state),
    .target   (target),
    .hash     (hash),
    .gn_match (gn_match)
  );

endmodule

`default_nettype wire

/* dv/keccak_miner_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module keccak_miner_tb
  import keccak_pkg::*;
();

  localparam int HASH_DELAY  = 49; // drive edge to the negedge where hash is stable
  localparam int DRAIN_LIMIT = 200;

  typedef struct packed {
    int unsigned tag;
    job_t        job;
  } sent_t;

  logic                clk = 1'b0;
  logic                rst_n;
  job_t                job;
  logic [TARGET_W-1:0] target;
  lane_t               hash;
  logic                gn_match;

  int unsigned cyc;
  sent_t       sent_q [$];
  logic        pending_match;
  int          hash_errs;
  int          match_errs;
  int          other_errs;
  int          jobs_checked;

  keccak_miner_top keccak_miner_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .job      (job),
    .target   (target),
    .hash     (hash),
    .gn_match (gn_match)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  function automatic lane_t rotate_left(input lane_t v, input int unsigned n);
    return (v << n) | (v >> (LANE_W - n));
  endfunction

  function automatic lane_t byte_swap(input lane_t v);
    lane_t r;
    for (int b = 0; b < 8; b++)
    begin
      r[8*b +: 8] = v[8*(7-b) +: 8];
    end
    return r;
  endfunction

  // reference model with lanes held as a[x][y]
  function automatic lane_t keccak_hash(input job_t j);
    logic [RATE_W-1:0] blk;
    lane_t a [5][5];
    lane_t b [5][5];
    lane_t c [5];
    lane_t d [5];
    blk = {j.header, j.nonce, 8'h01, {(RATE_W - HEADER_W - NONCE_W - 16){1'b0}}, 8'h80};
    for (int x = 0; x < 5; x++)
    begin
      for (int y = 0; y < 5; y++)
      begin
        a[x][y] = '0;
      end
    end
    for (int i = 0; i < RATE_W / LANE_W; i++)
    begin
      a[i % 5][i / 5] = byte_swap(blk[RATE_W-1-i*LANE_W -: LANE_W]);
    end
    for (int r = 0; r < NUM_ROUNDS; r++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
      end
      for (int x = 0; x < 5; x++)
      begin
        d[x] = c[(x + 4) % 5] ^ rotate_left(c[(x + 1) % 5], 1);
      end
      // theta, rho and pi in one sweep
      for (int x = 0; x < 5; x++)
      begin
        for (int y = 0; y < 5; y++)
        begin
          b[y][(2*x + 3*y) % 5] = rotate_left(a[x][y] ^ d[x], ROT_OFFSETS[y][x]);
        end
      end
      for (int x = 0; x < 5; x++)
      begin
        for (int y = 0; y < 5; y++)
        begin
          a[x][y] = b[x][y] ^ (~b[(x + 1) % 5][y] & b[(x + 2) % 5][y]);
        end
      end
      a[0][0] = a[0][0] ^ round_constant(r);
    end
    return a[HASH_LANE_X][HASH_LANE_Y];
  endfunction

  function automatic job_t random_job();
    job_t j;
    for (int i = 0; i < HEADER_W / 32; i++)
    begin
      j.header[i*32 +: 32] = $urandom();
    end
    j.nonce = $urandom();
    return j;
  endfunction

  task automatic check_hash(input lane_t actual, input lane_t expected);
    if (actual !== expected)
    begin
      hash_errs++;
      $display("[FAIL] hash: expected %h, got %h (cycle %0d)", expected, actual, cyc);
    end
  endtask

  task automatic check_match(input logic actual, input logic expected);
    if (actual !== expected)
    begin
      match_errs++;
      $display("[FAIL] gn_match: expected %h, got %h (cycle %0d)", expected, actual, cyc);
    end
  endtask

  task automatic drive_job(input job_t j, input logic [TARGET_W-1:0] t);
    sent_t s;
    @(posedge clk);
    job    <= j;
    target <= t;
    s.tag = cyc;
    s.job = j;
    sent_q.push_back(s);
  endtask

  // scoreboard sampling mid-cycle
  initial
  begin : compare
    sent_t s;
    lane_t exp_hash;
    logic  exp_match;
    logic  rst_prev;
    rst_prev = 1'b0; // reset is low from time zero
    forever
    begin
      @(negedge clk);
      if (rst_prev === 1'b0)
      begin
        check_match(gn_match, 1'b0); // reset sampled on the last edge
      end
      rst_prev = rst_n;
      if (pending_match)
      begin
        check_match(gn_match, exp_match);
        pending_match = 1'b0;
      end
      if (sent_q.size() > 0 && sent_q[0].tag + HASH_DELAY == cyc)
      begin
        s = sent_q.pop_front();
        exp_hash = keccak_hash(s.job);
        check_hash(hash, exp_hash);
        exp_match = (exp_hash[LANE_W-1 -: TARGET_W] <= target); // target seen by next edge
        pending_match = 1'b1;
        jobs_checked++;
      end
    end
  end

  initial
  begin : stimulus
    job_t                j;
    logic [HEADER_W-1:0] fixed_hdr;
    logic [TARGET_W-1:0] tgt;
    int                  waited;
    rst_n         = 1'b0;
    job           = '0;
    target        = '1;
    cyc           = 0;
    pending_match = 1'b0;
    hash_errs     = 0;
    match_errs    = 0;
    other_errs    = 0;
    jobs_checked  = 0;
    void'($urandom(2289));

    for (int i = 0; i < 10; i++)
    begin
      drive_job('0, '1);
    end
    rst_n <= 1'b1;

    // directed patterns
    drive_job('0, '1);
    j.header = '1;
    j.nonce  = '0;
    drive_job(j, '1);
    j.nonce  = '1;
    drive_job(j, '1);

    // back to back stream with every share accepted
    for (int i = 0; i < 200; i++)
    begin
      drive_job(random_job(), '1);
    end

    // nonce sweep under the tightest target
    fixed_hdr = random_job().header;
    for (int n = 0; n < 64; n++)
    begin
      j.header = fixed_hdr;
      j.nonce  = n;
      drive_job(j, '0);
    end

    tgt = '0;
    for (int i = 0; i < 320; i++)
    begin
      if (i % 64 == 0)
      begin
        tgt = $urandom();
      end
      drive_job(random_job(), tgt);
    end

    waited = 0;
    while ((sent_q.size() != 0 || pending_match) && waited < DRAIN_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (sent_q.size() != 0 || pending_match)
    begin
      other_errs++;
      $display("timeout: %0d jobs still waiting for a hash", sent_q.size());
    end

    $display("jobs checked %0d, hash errors %0d, gn_match errors %0d, other errors %0d",
             jobs_checked, hash_errs, match_errs, other_errs);
    if (hash_errs + match_errs + other_errs == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* keccak_miner_top.f */
design/keccak_pkg.sv
design/keccak_absorb.sv
design/keccak_round.sv
design/keccak_pipeline.sv
design/share_check.sv
design/keccak_miner_top.sv
dv/keccak_miner_tb.sv
